//--- rtl/fe_pkg.sv
package fe_pkg;

	// radix 2^8 layout, limb 0 least significant
	localparam int NUM_LIMBS = 32;

	// one radix-2^8 limb
	typedef logic [7:0] limb_t;

	// column accumulator, holds 32 folded 8x8 products
	typedef logic [31:0] word_t;

	// column / pass index
	typedef logic [4:0] pass_idx_t;

	// 256-bit field element
	typedef limb_t [NUM_LIMBS-1:0] fe_t;

	// per-limb product vector
	typedef word_t [NUM_LIMBS-1:0] wide_t;

	// one multiply request
	typedef struct packed {
		fe_t a;
		fe_t b;
	} mul_req_t;

	// operand set for a single column pass
	typedef struct packed {
		pass_idx_t idx;
		fe_t       a;
		fe_t       b_rot;
	} pass_t;

	// 2^256 = 38 mod p, used for wrapped column terms
	localparam word_t FOLD_MUL = 32'd38;

	// 2^255 = 19 mod p, used when squeezing the top limb
	localparam word_t TOP_FOLD = 32'd19;

endpackage

//--- rtl/reduction_adder.sv
`timescale 1ns/1ps

module reduction_adder #(
	parameter int IN_BLOCKS = 32,
	parameter int FANIN     = 4
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  in_vld,
	input  fe_pkg::word_t [IN_BLOCKS-1:0]         din,
	output logic                                  out_vld,
	output fe_pkg::word_t [IN_BLOCKS/FANIN-1:0]   dout
);
	import fe_pkg::*;

	localparam int OUT_BLOCKS = IN_BLOCKS / FANIN;

	word_t [OUT_BLOCKS-1:0] sums;

	// group k sums input words k*FANIN .. k*FANIN+FANIN-1
	always_comb begin
		for (int k = 0; k < OUT_BLOCKS; k++) begin
			sums[k] = '0;
			for (int m = 0; m < FANIN; m++) begin
				sums[k] = sums[k] + din[k*FANIN + m];
			end
		end
	end

	// valid follows data by one level
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_vld <= 1'b0;
		end else begin
			out_vld <= in_vld;
		end
	end

	// level output register
	always_ff @(posedge clk) begin
		if (in_vld) begin
			dout <= sums;
		end
	end

endmodule

//--- rtl/mult_pass.sv
`timescale 1ns/1ps

module mult_pass #(
	parameter int FANIN = 4
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          pass_vld,
	input  fe_pkg::pass_t pass,
	output logic          col_vld,
	output fe_pkg::word_t col_sum
);
	import fe_pkg::*;

	// tree shape, always three levels so latency stays fixed
	// second level fan-in clamps when the first level already shrank far
	localparam int N1 = NUM_LIMBS / FANIN;
	localparam int F2 = (N1 > FANIN) ? FANIN : N1;
	localparam int N2 = N1 / F2;

	logic                   prod_vld;
	wide_t                  prod;
	logic [NUM_LIMBS-1:0]   fold_mask;
	logic                   fold_vld;
	wide_t                  folded;
	logic                   lvl1_vld;
	word_t [N1-1:0]         lvl1;
	logic                   lvl2_vld;
	word_t [N2-1:0]         lvl2;

	// valid chain through the two multiply stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prod_vld <= 1'b0;
			fold_vld <= 1'b0;
		end else begin
			prod_vld <= pass_vld;
			fold_vld <= prod_vld;
		end
	end

	// stage one, limb products and wrap mask
	// terms with j > i come from the upper half and wrap past 2^256
	always_ff @(posedge clk) begin
		if (pass_vld) begin
			for (int j = 0; j < NUM_LIMBS; j++) begin
				prod[j]      <= word_t'(pass.a[j]) * word_t'(pass.b_rot[j]);
				fold_mask[j] <= (j > int'(pass.idx));
			end
		end
	end

	// stage two, scale wrapped terms by 38
	always_ff @(posedge clk) begin
		if (prod_vld) begin
			for (int j = 0; j < NUM_LIMBS; j++) begin
				folded[j] <= fold_mask[j] ? prod[j] * FOLD_MUL : prod[j];
			end
		end
	end

	// adder tree, 32 -> N1
	reduction_adder #(
		.IN_BLOCKS (NUM_LIMBS),
		.FANIN     (FANIN)
	) u_level1 (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_vld  (fold_vld),
		.din     (folded),
		.out_vld (lvl1_vld),
		.dout    (lvl1)
	);

	// N1 -> N2
	reduction_adder #(
		.IN_BLOCKS (N1),
		.FANIN     (F2)
	) u_level2 (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_vld  (lvl1_vld),
		.din     (lvl1),
		.out_vld (lvl2_vld),
		.dout    (lvl2)
	);

	// last level folds whatever is left into one word
	reduction_adder #(
		.IN_BLOCKS (N2),
		.FANIN     (N2)
	) u_level3 (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_vld  (lvl2_vld),
		.din     (lvl2),
		.out_vld (col_vld),
		.dout    (col_sum)
	);

endmodule

//--- rtl/operand_rotator.sv
`timescale 1ns/1ps

module operand_rotator (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue,
	input  fe_pkg::pass_idx_t issue_idx,
	input  fe_pkg::mul_req_t  op,
	output logic              pass_vld,
	output fe_pkg::pass_t     pass
);
	import fe_pkg::*;

	fe_t b_rot;

	// limb pair j of column i pairs a[j] with b[(i - j) mod 32]
	// index math wraps in 5 bits
	always_comb begin
		for (int j = 0; j < NUM_LIMBS; j++) begin
			b_rot[j] = op.b[pass_idx_t'(issue_idx - pass_idx_t'(j))];
		end
	end

	// valid strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pass_vld <= 1'b0;
		end else begin
			pass_vld <= issue;
		end
	end

	// operand register, first stage of the pass pipeline
	always_ff @(posedge clk) begin
		if (issue) begin
			pass.idx   <= issue_idx;
			pass.a     <= op.a;
			pass.b_rot <= b_rot;
		end
	end

endmodule

//--- rtl/squeeze_unit.sv
`timescale 1ns/1ps

module squeeze_unit (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          col_vld,
	input  fe_pkg::word_t col_sum,
	output logic          col_full,
	input  logic          sq_go,
	output logic          done,
	output fe_pkg::fe_t   result
);
	import fe_pkg::*;

	localparam pass_idx_t LAST = pass_idx_t'(NUM_LIMBS - 1);

	word_t      mem [NUM_LIMBS];
	pass_idx_t  wptr;
	logic [5:0] step;
	logic [5:0] cur_step;
	logic       active;
	logic       running;
	logic       fin;
	pass_idx_t  limb_sel;
	logic       round;
	word_t      carry;
	word_t      carry_in;
	word_t      sum;

	// sq_go itself performs step 0 with an empty carry
	assign running  = sq_go || active;
	assign cur_step = sq_go ? 6'd0 : step;
	assign limb_sel = cur_step[4:0];
	assign round    = cur_step[5];
	assign carry_in = sq_go ? '0 : carry;
	assign sum      = carry_in + mem[limb_sel];

	// column store, then in-place carry write-back
	always_ff @(posedge clk) begin
		if (col_vld) begin
			mem[wptr] <= col_sum;
		end else if (running) begin
			// top limb keeps 7 bits in round 0, 8 bits in round 1
			if (limb_sel == LAST && !round) begin
				mem[limb_sel] <= word_t'(sum[6:0]);
			end else begin
				mem[limb_sel] <= word_t'(sum[7:0]);
			end
		end
	end

	// carry out of each limb
	// bits 255 and up wrap to the bottom times 19
	always_ff @(posedge clk) begin
		if (running) begin
			if (limb_sel == LAST && !round) begin
				carry <= TOP_FOLD * (sum >> 7);
			end else begin
				carry <= sum >> 8;
			end
		end
	end

	// write pointer, step counter and strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr     <= '0;
			col_full <= 1'b0;
			step     <= '0;
			active   <= 1'b0;
			fin      <= 1'b0;
			done     <= 1'b0;
		end else begin
			col_full <= col_vld && (wptr == LAST);
			if (col_vld) begin
				wptr <= wptr + 1'b1;
			end
			// 64 steps, two rounds of 32 limbs
			if (running) begin
				step   <= cur_step + 1'b1;
				active <= (cur_step != 6'd63);
			end
			fin  <= running && (cur_step == 6'd63);
			done <= fin;
		end
	end

	// output register, held until the next squeeze
	always_ff @(posedge clk) begin
		if (fin) begin
			for (int j = 0; j < NUM_LIMBS; j++) begin
				result[j] <= mem[j][7:0];
			end
		end
	end

endmodule

//--- rtl/mul_ctrl.sv
`timescale 1ns/1ps

module mul_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  fe_pkg::mul_req_t  req,
	output logic              issue,
	output fe_pkg::pass_idx_t issue_idx,
	output fe_pkg::mul_req_t  op,
	input  logic              col_full,
	output logic              sq_go,
	input  logic              done,
	output logic              busy
);
	import fe_pkg::*;

	localparam pass_idx_t LAST = pass_idx_t'(NUM_LIMBS - 1);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN,
		SQUEEZE
	} state_t;

	state_t state;

	// one pass per cycle while issuing
	assign issue = (state == ISSUE);
	assign busy  = (state != IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			issue_idx <= '0;
			sq_go     <= 1'b0;
		end else begin
			sq_go <= 1'b0;
			case (state)
				// starts while busy never reach this branch
				IDLE: begin
					if (start) begin
						state     <= ISSUE;
						issue_idx <= '0;
					end
				end
				ISSUE: begin
					issue_idx <= issue_idx + 1'b1;
					if (issue_idx == LAST) begin
						state <= DRAIN;
					end
				end
				// passes still in the pipeline
				DRAIN: begin
					if (col_full) begin
						sq_go <= 1'b1;
						state <= SQUEEZE;
					end
				end
				SQUEEZE: begin
					if (done) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// operand latch
	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			op <= req;
		end
	end

endmodule

//--- rtl/fe_mul_top.sv
`timescale 1ns/1ps

module fe_mul_top #(
	parameter int FANIN = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  fe_pkg::mul_req_t req,
	output logic             busy,
	output logic             done,
	output fe_pkg::fe_t      result
);
	import fe_pkg::*;

	logic      issue;
	pass_idx_t issue_idx;
	mul_req_t  op;
	logic      pass_vld;
	pass_t     pass;
	logic      col_vld;
	word_t     col_sum;
	logic      col_full;
	logic      sq_go;

	// request accept and pass sequencing
	mul_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.req       (req),
		.issue     (issue),
		.issue_idx (issue_idx),
		.op        (op),
		.col_full  (col_full),
		.sq_go     (sq_go),
		.done      (done),
		.busy      (busy)
	);

	// per-column operand set
	operand_rotator u_rot (
		.clk       (clk),
		.rst_n     (rst_n),
		.issue     (issue),
		.issue_idx (issue_idx),
		.op        (op),
		.pass_vld  (pass_vld),
		.pass      (pass)
	);

	// 5-stage column multiply and sum
	mult_pass #(
		.FANIN (FANIN)
	) u_pass (
		.clk      (clk),
		.rst_n    (rst_n),
		.pass_vld (pass_vld),
		.pass     (pass),
		.col_vld  (col_vld),
		.col_sum  (col_sum)
	);

	// column collect and carry rounds
	squeeze_unit u_sq (
		.clk      (clk),
		.rst_n    (rst_n),
		.col_vld  (col_vld),
		.col_sum  (col_sum),
		.col_full (col_full),
		.sq_go    (sq_go),
		.done     (done),
		.result   (result)
	);

endmodule

//--- tests/fe_mul_props.sv
`timescale 1ns/1ps

module fe_mul_props (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input logic col_full,
	input logic sq_go,
	input logic done,
	input logic busy
);

	// one pass per cycle, 32 back to back, then issue drops
	issue_burst: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(issue) |-> $past(issue, 32) && !$past(issue, 33))
		else $error("issue burst not 32 cycles long");

	// squeeze starts the cycle after the last column lands
	go_after_full: assert property (@(posedge clk) disable iff (!rst_n) col_full |=> sq_go)
		else $error("sq_go missing after col_full");

	// done only while busy, busy drops right after it
	busy_fall: assert property (@(posedge clk) disable iff (!rst_n) done |=> $fell(busy))
		else $error("busy did not fall after done");

endmodule

bind mul_ctrl fe_mul_props u_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.issue    (issue),
	.col_full (col_full),
	.sq_go    (sq_go),
	.done     (done),
	.busy     (busy)
);

//--- tests/fe_mul_tb.sv
`timescale 1ns/1ps

module fe_mul_tb;
	import fe_pkg::*;

	localparam int NUM_TESTS = 10;
	// room for 12 runs of about 110 cycles, doubled
	localparam int MAX_CYCLES = 12 * 110 * 2;
	// 2^255 - 19
	localparam logic [255:0] P = (256'd1 << 255) - 256'd19;
	localparam logic [511:0] P_WIDE = {256'd0, P};

	logic     clk;
	logic     rst_n;
	logic     start;
	mul_req_t req;
	logic     busy;
	logic     done;
	fe_t      result;

	// stimulus table with expected residues
	logic [255:0] tbl_a [NUM_TESTS];
	logic [255:0] tbl_b [NUM_TESTS];
	logic [255:0] tbl_exp [NUM_TESTS];
	logic         tbl_spur [NUM_TESTS];

	integer seed;
	int     checks;
	int     errors;
	int     cycles = 0;

	fe_mul_top #(
		.FANIN (4)
	) uut (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.req    (req),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// a*b mod p with a full 512-bit product
	function automatic logic [255:0] ref_mul(input logic [255:0] a, input logic [255:0] b);
		logic [511:0] prod;
		prod = {256'd0, a} * {256'd0, b};
		return 256'(prod % P_WIDE);
	endfunction

	// eight 32-bit draws, first draw ends up on top
	task automatic rand_fe(output logic [255:0] v);
		v = '0;
		for (int k = 0; k < 8; k++) begin
			v = {v[223:0], 32'($random(seed))};
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic build_table();
		logic [255:0] r;
		tbl_a[0] = 256'd0;
		tbl_b[0] = 256'h0123456789abcdef_fedcba9876543210_0f1e2d3c4b5a6978_8796a5b4c3d2e1f0;
		tbl_a[1] = 256'd1;
		tbl_b[1] = 256'hfedcba9876543210_0123456789abcdef_c3d2e1f08796a5b4_4b5a69780f1e2d3c;
		tbl_a[2] = P - 256'd1;
		tbl_b[2] = P - 256'd1;
		// top bit clear, all others set
		tbl_a[3] = {1'b0, {255{1'b1}}};
		tbl_b[3] = {1'b0, {255{1'b1}}};
		// both operands above p
		tbl_a[4] = '1;
		tbl_b[4] = '1;
		tbl_a[5] = tbl_b[0];
		tbl_b[5] = tbl_b[1];
		tbl_a[6] = P + 256'd7;
		tbl_b[6] = 256'd121666;
		tbl_a[7] = (256'd1 << 128) + 256'd3;
		tbl_b[7] = (256'd1 << 200) - 256'd1;
		for (int i = 8; i < NUM_TESTS; i++) begin
			rand_fe(r);
			tbl_a[i] = r;
			rand_fe(r);
			tbl_b[i] = r;
		end
		for (int i = 0; i < NUM_TESTS; i++) begin
			tbl_exp[i]  = ref_mul(tbl_a[i], tbl_b[i]);
			tbl_spur[i] = (i == 7);
		end
	endtask

	// one request, called and left at 5 ns past a rising edge
	task automatic run_entry(input int idx);
		int           cyc;
		logic [511:0] wide;
		check_bit("busy", busy, 1'b0);
		start = 1'b1;
		req.a = tbl_a[idx];
		req.b = tbl_b[idx];
		@(posedge clk);
		#5;
		start = 1'b0;
		cyc   = 0;
		// accepted, busy now up
		check_bit("busy", busy, 1'b1);
		while (!done) begin
			// second request mid-run, must be dropped
			if (tbl_spur[idx] && cyc == 10) begin
				start = 1'b1;
				req.a = 256'd5;
				req.b = 256'd7;
			end else begin
				start = 1'b0;
			end
			@(posedge clk);
			#5;
			cyc++;
			check_bit("busy", busy, 1'b1);
		end
		start = 1'b0;
		checks++;
		if ($isunknown(result)) begin
			errors++;
			$display("entry %0d: result has unknown bits at %0t", idx, $time);
		end
		// compare residues, the DUT output need not be below p
		wide = {256'd0, result} % P_WIDE;
		check_value("result mod p", 256'(wide), tbl_exp[idx]);
		// exactly one done, then idle
		repeat (4) begin
			@(posedge clk);
			#5;
			check_bit("done", done, 1'b0);
			check_bit("busy", busy, 1'b0);
		end
	endtask

	initial begin
		seed   = 32'hb9ed;
		checks = 0;
		errors = 0;
		rst_n  = 1'b0;
		start  = 1'b0;
		req    = '0;
		build_table();
		repeat (3) @(posedge clk);
		#5;
		rst_n = 1'b1;
		// quiet after reset, no start yet
		repeat (6) begin
			@(posedge clk);
			#5;
			check_bit("busy", busy, 1'b0);
			check_bit("done", done, 1'b0);
		end
		for (int i = 0; i < NUM_TESTS; i++) begin
			run_entry(i);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- all.f
rtl/fe_pkg.sv
rtl/reduction_adder.sv
rtl/mult_pass.sv
rtl/operand_rotator.sv
rtl/squeeze_unit.sv
rtl/mul_ctrl.sv
rtl/fe_mul_top.sv
tests/fe_mul_props.sv
tests/fe_mul_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module fe_mul_tb -o fe_mul_sim \
	&& ./obj_dir/fe_mul_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Some tests failed" sim.log 2>/dev/null && { echo "simulation FAILED"; exit 1; } \
	|| grep -q "All tests passed" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation FAILED, no result in log"; exit 1; }
